//--- src.f
common/csr_pkg.sv
csr/csr_regfile.sv
csr/trap_ctrl.sv
csr/csr_counters.sv
verilog/csr_unit.sv
tests/csr_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module csr_tb -f src.f -o csr_sim
./obj_dir/csr_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "NO ERRORS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

//--- tests/csr_tb.sv
module csr_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALF = 20;
	localparam int TIMEOUT = 200;
	localparam int NUM_ACCESSES = 300;

	logic                clk_i;
	logic                rst_i;
	csr_pkg::csr_req_t   csr_req;
	csr_pkg::trap_req_t  trap_req;
	logic                xret;
	logic                retire;
	csr_pkg::irq_lines_t irq;
	csr_pkg::xlen_t      csr_rdata;
	logic                csr_illegal;
	logic                irq_pending;
	logic                redirect;
	csr_pkg::xlen_t      redirect_pc;

	// Reference model state
	logic                m_mstatus_mie;
	logic                m_mstatus_mpie;
	csr_pkg::irq_lines_t m_mie;
	csr_pkg::xlen_t      m_mtvec;
	csr_pkg::xlen_t      m_mscratch;
	csr_pkg::xlen_t      m_mepc;
	csr_pkg::xlen_t      m_mtval;
	logic                m_mcause_int;
	csr_pkg::cause_t     m_mcause_code;
	logic [63:0]         m_mcycle;
	logic [63:0]         m_minstret;

	csr_pkg::irq_lines_t cur_irq;
	logic [31:0]         lcg_state;
	csr_pkg::csr_addr_t  addr_tbl [20];

	csr_unit i_csr_unit (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.csr_req_i     (csr_req),
		.trap_i        (trap_req),
		.xret_i        (xret),
		.retire_i      (retire),
		.irq_i         (irq),
		.csr_rdata_o   (csr_rdata),
		.csr_illegal_o (csr_illegal),
		.irq_pending_o (irq_pending),
		.redirect_o    (redirect),
		.redirect_pc_o (redirect_pc)
	);

	initial begin
		clk_i = 1'b0;
		forever #(HALF) clk_i = ~clk_i;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] rand_below(input logic [31:0] n);
		return (next_rand() >> 8) % n;
	endfunction

	task automatic compare(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s expected %0h actual %0h", name, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1, "Value mismatch");
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("Timed out while %s", what);
		$display("ERRORS FOUND");
		$fatal(1, "Timeout");
	endtask

	// Interrupt bits sit at 3, 7 and 11 in mie and mip
	function automatic csr_pkg::xlen_t lines_image(input csr_pkg::irq_lines_t l);
		csr_pkg::xlen_t img;
		img = '0;
		img[3] = l[0];
		img[7] = l[1];
		img[11] = l[2];
		return img;
	endfunction

	function automatic csr_pkg::cause_t irq_code(input csr_pkg::irq_lines_t act);
		if (act[2])
			return csr_pkg::IRQ_EXT;
		else if (act[0])
			return csr_pkg::IRQ_SOFT;
		return csr_pkg::IRQ_TIMER;
	endfunction

	task automatic model_read(input csr_pkg::csr_addr_t addr, output csr_pkg::xlen_t val,
		output logic known, output logic ro);
		val = '0;
		known = 1'b1;
		ro = 1'b0;
		case (addr)
			csr_pkg::ADDR_MISA: begin
				val = csr_pkg::MISA_VALUE;
				ro = 1'b1;
			end
			csr_pkg::ADDR_MHARTID: begin
				val = csr_pkg::HART_ID;
				ro = 1'b1;
			end
			csr_pkg::ADDR_MVENDORID, csr_pkg::ADDR_MARCHID, csr_pkg::ADDR_MIMPID: ro = 1'b1;
			csr_pkg::ADDR_MIP: begin
				val = lines_image(cur_irq);
				ro = 1'b1;
			end
			csr_pkg::ADDR_MSTATUS:
				val = 32'h1800 | (32'(m_mstatus_mpie) << 7) | (32'(m_mstatus_mie) << 3);
			csr_pkg::ADDR_MIE:       val = lines_image(m_mie);
			csr_pkg::ADDR_MTVEC:     val = m_mtvec;
			csr_pkg::ADDR_MSCRATCH:  val = m_mscratch;
			csr_pkg::ADDR_MEPC:      val = m_mepc;
			csr_pkg::ADDR_MCAUSE:    val = {m_mcause_int, 27'b0, m_mcause_code};
			csr_pkg::ADDR_MTVAL:     val = m_mtval;
			csr_pkg::ADDR_MCYCLE:    val = m_mcycle[31:0];
			csr_pkg::ADDR_MCYCLEH:   val = m_mcycle[63:32];
			csr_pkg::ADDR_MINSTRET:  val = m_minstret[31:0];
			csr_pkg::ADDR_MINSTRETH: val = m_minstret[63:32];
			default: known = 1'b0;
		endcase
	endtask

	function automatic csr_pkg::csr_req_t make_req(input csr_pkg::csr_op_e op,
		input csr_pkg::csr_addr_t addr, input logic rs1_nz, input csr_pkg::xlen_t operand);
		csr_pkg::csr_req_t r;
		r.op = op;
		r.addr = addr;
		r.rs1_nz = rs1_nz;
		r.operand = operand;
		return r;
	endfunction

	// Drives one cycle, checks the outputs and advances the model
	task automatic step(input csr_pkg::csr_req_t req, input csr_pkg::trap_req_t trap,
		input logic do_xret, input logic do_retire, input string name);
		csr_pkg::xlen_t      exp_rd;
		csr_pkg::xlen_t      wdata;
		csr_pkg::irq_lines_t act;
		logic                known;
		logic                ro;
		logic                access;
		logic                wr;
		@(negedge clk_i);
		rst_i = 1'b0;
		csr_req = req;
		trap_req = trap;
		xret = do_xret;
		retire = do_retire;
		irq = cur_irq;
		#(HALF - 2);
		model_read(req.addr, exp_rd, known, ro);
		access = (req.op != csr_pkg::CSR_NONE);
		wr = access && ((req.op == csr_pkg::CSR_WRITE) || req.rs1_nz);
		act = cur_irq & m_mie & {3{m_mstatus_mie}};
		if (access)
			compare({name, " rdata"}, 64'(exp_rd), 64'(csr_rdata));
		compare({name, " illegal"}, 64'(access && (!known || (ro && wr))), 64'(csr_illegal));
		compare({name, " irq_pending"}, 64'(|act), 64'(irq_pending));
		compare({name, " redirect"}, 64'(trap.valid || do_xret), 64'(redirect));
		if (trap.valid || do_xret)
			compare({name, " redirect_pc"}, 64'(trap.valid ? m_mtvec : m_mepc),
				64'(redirect_pc));
		case (req.op)
			csr_pkg::CSR_WRITE: wdata = req.operand;
			csr_pkg::CSR_SET:   wdata = exp_rd | req.operand;
			csr_pkg::CSR_CLEAR: wdata = exp_rd & ~req.operand;
			default:            wdata = '0;
		endcase
		wr = wr && known && !ro;
		if (wr && req.addr == csr_pkg::ADDR_MCYCLE)
			m_mcycle[31:0] = wdata;
		else if (wr && req.addr == csr_pkg::ADDR_MCYCLEH)
			m_mcycle[63:32] = wdata;
		else
			m_mcycle = m_mcycle + 64'd1;
		if (wr && req.addr == csr_pkg::ADDR_MINSTRET)
			m_minstret[31:0] = wdata;
		else if (wr && req.addr == csr_pkg::ADDR_MINSTRETH)
			m_minstret[63:32] = wdata;
		else if (do_retire)
			m_minstret = m_minstret + 64'd1;
		if (wr && req.addr == csr_pkg::ADDR_MTVEC)
			m_mtvec = {wdata[31:2], 2'b00};
		if (wr && req.addr == csr_pkg::ADDR_MSCRATCH)
			m_mscratch = wdata;
		if (trap.valid) begin
			m_mepc = {trap.pc[31:2], 2'b00};
			m_mcause_int = |act;
			m_mcause_code = (|act) ? irq_code(act) : trap.cause;
			m_mtval = trap.tval;
			m_mstatus_mpie = m_mstatus_mie;
			m_mstatus_mie = 1'b0;
		end else if (do_xret) begin
			m_mstatus_mie = m_mstatus_mpie;
			m_mstatus_mpie = 1'b1;
		end else if (wr) begin
			case (req.addr)
				csr_pkg::ADDR_MSTATUS: begin
					m_mstatus_mie = wdata[3];
					m_mstatus_mpie = wdata[7];
				end
				csr_pkg::ADDR_MIE:    m_mie = {wdata[11], wdata[7], wdata[3]};
				csr_pkg::ADDR_MEPC:   m_mepc = {wdata[31:2], 2'b00};
				csr_pkg::ADDR_MCAUSE: begin
					m_mcause_int = wdata[31];
					m_mcause_code = wdata[3:0];
				end
				csr_pkg::ADDR_MTVAL:  m_mtval = wdata;
				default: ;
			endcase
		end
		@(posedge clk_i);
	endtask

	// SET with rs1 zero reads without writing
	task automatic read_csr(input csr_pkg::csr_addr_t addr, input string name);
		step(make_req(csr_pkg::CSR_SET, addr, 1'b0, next_rand()), '0, 1'b0, 1'b0, name);
	endtask

	task automatic write_csr(input csr_pkg::csr_addr_t addr, input csr_pkg::xlen_t data,
		input string name);
		step(make_req(csr_pkg::CSR_WRITE, addr, 1'b1, data), '0, 1'b0, 1'b0, name);
	endtask

	task automatic take_trap(input string name);
		csr_pkg::trap_req_t t;
		logic [31:0]        r;
		r = next_rand();
		t.valid = 1'b1;
		t.cause = r[31:28];
		t.pc = next_rand();
		t.tval = next_rand();
		step(make_req(csr_pkg::CSR_NONE, '0, 1'b0, '0), t, 1'b0, 1'b0, name);
		read_csr(csr_pkg::ADDR_MEPC, {name, " mepc"});
		read_csr(csr_pkg::ADDR_MCAUSE, {name, " mcause"});
		read_csr(csr_pkg::ADDR_MTVAL, {name, " mtval"});
		read_csr(csr_pkg::ADDR_MSTATUS, {name, " mstatus"});
	endtask

	task automatic random_accesses();
		csr_pkg::csr_op_e   op;
		csr_pkg::csr_addr_t addr;
		logic [31:0]        r;
		logic [4:0]         idx;
		for (int i = 0; i < NUM_ACCESSES; i++) begin
			r = rand_below(20);
			idx = r[4:0];
			addr = addr_tbl[idx];
			r = rand_below(3);
			case (r)
				32'd0:   op = csr_pkg::CSR_WRITE;
				32'd1:   op = csr_pkg::CSR_SET;
				default: op = csr_pkg::CSR_CLEAR;
			endcase
			r = next_rand();
			step(make_req(op, addr, r[30], next_rand()), '0, 1'b0, 1'b0, "random access");
			read_csr(addr, "random readback");
		end
	endtask

	task automatic trap_and_return();
		logic [31:0] r;
		cur_irq = '0;
		for (int i = 0; i < 10; i++) begin
			r = next_rand();
			write_csr(csr_pkg::ADDR_MSTATUS, r & 32'h88, "trap mstatus setup");
			write_csr(csr_pkg::ADDR_MTVEC, next_rand(), "trap mtvec setup");
			take_trap("trap entry");
			// An mie write in the mret cycle must be dropped
			step(make_req(csr_pkg::CSR_WRITE, csr_pkg::ADDR_MIE, 1'b1, next_rand()), '0, 1'b1,
				1'b0, "mret");
			read_csr(csr_pkg::ADDR_MSTATUS, "mret mstatus");
			read_csr(csr_pkg::ADDR_MIE, "mret mie");
		end
	endtask

	task automatic interrupts();
		logic [31:0] r;
		for (int i = 0; i < 40; i++) begin
			r = next_rand();
			cur_irq = r[30:28];
			write_csr(csr_pkg::ADDR_MIE, next_rand(), "irq mie");
			r = next_rand();
			write_csr(csr_pkg::ADDR_MSTATUS, {24'b0, r[31], 3'b0, r[29], 3'b0}, "irq mstatus");
			read_csr(csr_pkg::ADDR_MIP, "irq mip");
			if (r[27])
				take_trap("irq trap");
		end
		cur_irq = '0;
	endtask

	task automatic counters();
		int          pulses;
		int          target;
		int          n;
		logic [31:0] r;
		write_csr(csr_pkg::ADDR_MCYCLEH, next_rand(), "mcycleh write");
		read_csr(csr_pkg::ADDR_MCYCLEH, "mcycleh readback");
		write_csr(csr_pkg::ADDR_MCYCLE, next_rand(), "mcycle write");
		read_csr(csr_pkg::ADDR_MCYCLE, "mcycle readback");
		write_csr(csr_pkg::ADDR_MINSTRETH, next_rand(), "minstreth write");
		read_csr(csr_pkg::ADDR_MINSTRETH, "minstreth readback");
		write_csr(csr_pkg::ADDR_MINSTRET, next_rand(), "minstret write");
		read_csr(csr_pkg::ADDR_MINSTRET, "minstret readback");
		r = rand_below(10);
		target = 5 + int'(r);
		pulses = 0;
		n = 0;
		while (pulses < target && n < TIMEOUT) begin
			r = next_rand();
			step(make_req(csr_pkg::CSR_NONE, '0, 1'b0, '0), '0, 1'b0, r[29], "retire");
			if (r[29])
				pulses++;
			n++;
		end
		if (pulses < target)
			timeout_fail("counting retire pulses");
		read_csr(csr_pkg::ADDR_MINSTRET, "minstret count");
		read_csr(csr_pkg::ADDR_MINSTRETH, "minstreth count");
		read_csr(csr_pkg::ADDR_MCYCLE, "mcycle count");
		read_csr(csr_pkg::ADDR_MCYCLEH, "mcycleh count");
	endtask

	initial begin
		rst_i = 1'b1;
		csr_req = '0;
		trap_req = '0;
		xret = 1'b0;
		retire = 1'b0;
		irq = '0;
		cur_irq = '0;
		lcg_state = 32'd3672;
		m_mstatus_mie = 1'b0;
		m_mstatus_mpie = 1'b0;
		m_mie = '0;
		m_mtvec = csr_pkg::MTVEC_RESET;
		m_mscratch = '0;
		m_mepc = '0;
		m_mtval = '0;
		m_mcause_int = 1'b0;
		m_mcause_code = csr_pkg::CAUSE_ILLEGAL;
		m_mcycle = '0;
		m_minstret = '0;
		addr_tbl = '{csr_pkg::ADDR_MSTATUS, csr_pkg::ADDR_MIE, csr_pkg::ADDR_MTVEC,
			csr_pkg::ADDR_MSCRATCH, csr_pkg::ADDR_MEPC, csr_pkg::ADDR_MCAUSE,
			csr_pkg::ADDR_MTVAL, csr_pkg::ADDR_MCYCLE, csr_pkg::ADDR_MCYCLEH,
			csr_pkg::ADDR_MINSTRET, csr_pkg::ADDR_MINSTRETH, csr_pkg::ADDR_MISA,
			csr_pkg::ADDR_MHARTID, csr_pkg::ADDR_MVENDORID, csr_pkg::ADDR_MARCHID,
			csr_pkg::ADDR_MIMPID, csr_pkg::ADDR_MIP, 12'h7c0, 12'h3a0, 12'hc00};
		repeat (8) @(posedge clk_i);
		// MPP stays fixed so mstatus reads 32'h1800 out of reset
		read_csr(csr_pkg::ADDR_MSTATUS, "reset mstatus");
		read_csr(csr_pkg::ADDR_MTVEC, "reset mtvec");
		read_csr(csr_pkg::ADDR_MIE, "reset mie");
		read_csr(csr_pkg::ADDR_MEPC, "reset mepc");
		read_csr(csr_pkg::ADDR_MCAUSE, "reset mcause");
		read_csr(csr_pkg::ADDR_MISA, "reset misa");
		read_csr(csr_pkg::ADDR_MHARTID, "reset mhartid");
		random_accesses();
		trap_and_return();
		interrupts();
		counters();
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- verilog/csr_unit.sv
module csr_unit (
	input  logic                clk_i,
	input  logic                rst_i,
	input  csr_pkg::csr_req_t   csr_req_i,
	input  csr_pkg::trap_req_t  trap_i,
	input  logic                xret_i,
	input  logic                retire_i,
	input  csr_pkg::irq_lines_t irq_i,
	output csr_pkg::xlen_t      csr_rdata_o,
	output logic                csr_illegal_o,
	output logic                irq_pending_o,
	output logic                redirect_o,
	output csr_pkg::xlen_t      redirect_pc_o
);

	csr_pkg::csr_wr_t   csr_wr;
	csr_pkg::trap_csr_t trap_csr;
	csr_pkg::xlen_t     mtvec;
	logic [63:0]        mcycle;
	logic [63:0]        minstret;

	csr_regfile i_csr_regfile (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.csr_req_i     (csr_req_i),
		.trap_csr_i    (trap_csr),
		.irq_i         (irq_i),
		.mcycle_i      (mcycle),
		.minstret_i    (minstret),
		.csr_wr_o      (csr_wr),
		.mtvec_o       (mtvec),
		.csr_rdata_o   (csr_rdata_o),
		.csr_illegal_o (csr_illegal_o)
	);

	trap_ctrl i_trap_ctrl (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.csr_wr_i      (csr_wr),
		.trap_i        (trap_i),
		.xret_i        (xret_i),
		.irq_i         (irq_i),
		.mtvec_i       (mtvec),
		.trap_csr_o    (trap_csr),
		.irq_pending_o (irq_pending_o),
		.redirect_o    (redirect_o),
		.redirect_pc_o (redirect_pc_o)
	);

	csr_counters i_csr_counters (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.csr_wr_i   (csr_wr),
		.retire_i   (retire_i),
		.mcycle_o   (mcycle),
		.minstret_o (minstret)
	);

endmodule

//--- csr/csr_counters.sv
module csr_counters (
	input  logic             clk_i,
	input  logic             rst_i,
	input  csr_pkg::csr_wr_t csr_wr_i,
	input  logic             retire_i,
	output logic [63:0]      mcycle_o,
	output logic [63:0]      minstret_o
);

	logic [63:0] mcycle_q;
	logic [63:0] minstret_q;

	// A write to either half holds the other half and skips the increment
	function automatic logic [63:0] next_count(
		input logic [63:0]       cnt,
		input csr_pkg::csr_wr_t  wr,
		input csr_pkg::csr_sel_e sel_lo,
		input csr_pkg::csr_sel_e sel_hi,
		input logic              inc
	);
		logic [63:0] nxt;
		nxt = cnt;
		if (wr.en && (wr.sel == sel_lo))
			nxt[31:0] = wr.data;
		else if (wr.en && (wr.sel == sel_hi))
			nxt[63:32] = wr.data;
		else if (inc)
			nxt = cnt + 64'd1;
		return nxt;
	endfunction

	always_ff @(posedge clk_i) begin
		if (rst_i)
			mcycle_q <= '0;
		else
			mcycle_q <= next_count(mcycle_q, csr_wr_i, csr_pkg::SEL_MCYCLE,
				csr_pkg::SEL_MCYCLEH, 1'b1);
	end

	always_ff @(posedge clk_i) begin
		if (rst_i)
			minstret_q <= '0;
		else
			minstret_q <= next_count(minstret_q, csr_wr_i, csr_pkg::SEL_MINSTRET,
				csr_pkg::SEL_MINSTRETH, retire_i);
	end

	assign mcycle_o = mcycle_q;
	assign minstret_o = minstret_q;

endmodule

//--- csr/trap_ctrl.sv
module trap_ctrl (
	input  logic                clk_i,
	input  logic                rst_i,
	input  csr_pkg::csr_wr_t    csr_wr_i,
	input  csr_pkg::trap_req_t  trap_i,
	input  logic                xret_i,
	input  csr_pkg::irq_lines_t irq_i,
	input  csr_pkg::xlen_t      mtvec_i,
	output csr_pkg::trap_csr_t  trap_csr_o,
	output logic                irq_pending_o,
	output logic                redirect_o,
	output csr_pkg::xlen_t      redirect_pc_o
);

	logic                mstatus_mie_q;
	logic                mstatus_mpie_q;
	csr_pkg::irq_lines_t mie_q;
	csr_pkg::xlen_t      mepc_q;
	logic                mcause_int_q;
	csr_pkg::cause_t     mcause_code_q;
	csr_pkg::xlen_t      mtval_q;
	csr_pkg::irq_lines_t irq_active;
	csr_pkg::cause_t     irq_code;

	function automatic logic wr_hit(input csr_pkg::csr_wr_t wr, input csr_pkg::csr_sel_e sel);
		return wr.en && (wr.sel == sel);
	endfunction

	assign irq_active = irq_i & mie_q & {3{mstatus_mie_q}};
	assign irq_pending_o = |irq_active;

	// External first, then software, then timer
	always_comb begin
		if (irq_active[csr_pkg::IRQ_LINE_EXT])
			irq_code = csr_pkg::IRQ_EXT;
		else if (irq_active[csr_pkg::IRQ_LINE_SOFT])
			irq_code = csr_pkg::IRQ_SOFT;
		else
			irq_code = csr_pkg::IRQ_TIMER;
	end

	assign redirect_o = trap_i.valid || xret_i;
	assign redirect_pc_o = trap_i.valid ? mtvec_i : mepc_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mstatus_mie_q <= 1'b0;
			mstatus_mpie_q <= 1'b0;
		end else if (trap_i.valid) begin
			mstatus_mpie_q <= mstatus_mie_q;
			mstatus_mie_q <= 1'b0;
		end else if (xret_i) begin
			mstatus_mie_q <= mstatus_mpie_q;
			mstatus_mpie_q <= 1'b1;
		end else if (wr_hit(csr_wr_i, csr_pkg::SEL_MSTATUS)) begin
			mstatus_mie_q <= csr_wr_i.data[csr_pkg::MSTATUS_MIE_BIT];
			mstatus_mpie_q <= csr_wr_i.data[csr_pkg::MSTATUS_MPIE_BIT];
		end
	end

	// A trap or an xret blocks CSR writes in the same cycle
	always_ff @(posedge clk_i) begin
		if (rst_i)
			mie_q <= '0;
		else if (!trap_i.valid && !xret_i && wr_hit(csr_wr_i, csr_pkg::SEL_MIE))
			mie_q <= {csr_wr_i.data[11], csr_wr_i.data[7], csr_wr_i.data[3]};
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mepc_q <= '0;
			mcause_int_q <= 1'b0;
			mcause_code_q <= csr_pkg::CAUSE_ILLEGAL;
			mtval_q <= '0;
		end else if (trap_i.valid) begin
			mepc_q <= {trap_i.pc[31:2], 2'b00};
			mcause_int_q <= irq_pending_o;
			mcause_code_q <= irq_pending_o ? irq_code : trap_i.cause;
			mtval_q <= trap_i.tval;
		end else if (!xret_i) begin
			if (wr_hit(csr_wr_i, csr_pkg::SEL_MEPC))
				mepc_q <= {csr_wr_i.data[31:2], 2'b00};
			if (wr_hit(csr_wr_i, csr_pkg::SEL_MCAUSE)) begin
				mcause_int_q <= csr_wr_i.data[31];
				mcause_code_q <= csr_wr_i.data[3:0];
			end
			if (wr_hit(csr_wr_i, csr_pkg::SEL_MTVAL))
				mtval_q <= csr_wr_i.data;
		end
	end

	assign trap_csr_o.mstatus_mie = mstatus_mie_q;
	assign trap_csr_o.mstatus_mpie = mstatus_mpie_q;
	assign trap_csr_o.mie_bits = mie_q;
	assign trap_csr_o.mepc = mepc_q;
	assign trap_csr_o.mcause_int = mcause_int_q;
	assign trap_csr_o.mcause_code = mcause_code_q;
	assign trap_csr_o.mtval = mtval_q;

endmodule

//--- csr/csr_regfile.sv
module csr_regfile (
	input  logic                clk_i,
	input  logic                rst_i,
	input  csr_pkg::csr_req_t   csr_req_i,
	input  csr_pkg::trap_csr_t  trap_csr_i,
	input  csr_pkg::irq_lines_t irq_i,
	input  logic [63:0]         mcycle_i,
	input  logic [63:0]         minstret_i,
	output csr_pkg::csr_wr_t    csr_wr_o,
	output csr_pkg::xlen_t      mtvec_o,
	output csr_pkg::xlen_t      csr_rdata_o,
	output logic                csr_illegal_o
);

	csr_pkg::xlen_t   mtvec_q;
	csr_pkg::xlen_t   mscratch_q;
	csr_pkg::xlen_t   mstatus_img;
	csr_pkg::xlen_t   mcause_img;
	csr_pkg::xlen_t   rdata;
	csr_pkg::xlen_t   wdata;
	csr_pkg::csr_sel_e sel;
	logic             known;
	logic             read_only;
	logic             access;
	logic             wr_req;
	logic             wr_legal;

	// MSIE, MTIE, MEIE share their positions with MSIP, MTIP, MEIP
	function automatic csr_pkg::xlen_t irq_image(input csr_pkg::irq_lines_t lines);
		csr_pkg::xlen_t img;
		img = '0;
		img[3] = lines[csr_pkg::IRQ_LINE_SOFT];
		img[7] = lines[csr_pkg::IRQ_LINE_TIMER];
		img[11] = lines[csr_pkg::IRQ_LINE_EXT];
		return img;
	endfunction

	// MPP fixed at machine mode
	assign mstatus_img = {19'b0, 2'b11, 3'b0, trap_csr_i.mstatus_mpie, 3'b0,
		trap_csr_i.mstatus_mie, 3'b0};
	assign mcause_img = {trap_csr_i.mcause_int, 27'b0, trap_csr_i.mcause_code};

	// Address decode and read mux
	always_comb begin
		sel = csr_pkg::SEL_NONE;
		known = 1'b1;
		read_only = 1'b0;
		rdata = '0;
		case (csr_req_i.addr)
			csr_pkg::ADDR_MISA: begin
				rdata = csr_pkg::MISA_VALUE;
				read_only = 1'b1;
			end
			csr_pkg::ADDR_MHARTID: begin
				rdata = csr_pkg::HART_ID;
				read_only = 1'b1;
			end
			csr_pkg::ADDR_MVENDORID,
			csr_pkg::ADDR_MARCHID,
			csr_pkg::ADDR_MIMPID: read_only = 1'b1;
			csr_pkg::ADDR_MIP: begin
				rdata = irq_image(irq_i);
				read_only = 1'b1;
			end
			csr_pkg::ADDR_MSTATUS: begin
				rdata = mstatus_img;
				sel = csr_pkg::SEL_MSTATUS;
			end
			csr_pkg::ADDR_MIE: begin
				rdata = irq_image(trap_csr_i.mie_bits);
				sel = csr_pkg::SEL_MIE;
			end
			csr_pkg::ADDR_MTVEC: begin
				rdata = mtvec_q;
				sel = csr_pkg::SEL_MTVEC;
			end
			csr_pkg::ADDR_MSCRATCH: begin
				rdata = mscratch_q;
				sel = csr_pkg::SEL_MSCRATCH;
			end
			csr_pkg::ADDR_MEPC: begin
				rdata = trap_csr_i.mepc;
				sel = csr_pkg::SEL_MEPC;
			end
			csr_pkg::ADDR_MCAUSE: begin
				rdata = mcause_img;
				sel = csr_pkg::SEL_MCAUSE;
			end
			csr_pkg::ADDR_MTVAL: begin
				rdata = trap_csr_i.mtval;
				sel = csr_pkg::SEL_MTVAL;
			end
			csr_pkg::ADDR_MCYCLE: begin
				rdata = mcycle_i[31:0];
				sel = csr_pkg::SEL_MCYCLE;
			end
			csr_pkg::ADDR_MCYCLEH: begin
				rdata = mcycle_i[63:32];
				sel = csr_pkg::SEL_MCYCLEH;
			end
			csr_pkg::ADDR_MINSTRET: begin
				rdata = minstret_i[31:0];
				sel = csr_pkg::SEL_MINSTRET;
			end
			csr_pkg::ADDR_MINSTRETH: begin
				rdata = minstret_i[63:32];
				sel = csr_pkg::SEL_MINSTRETH;
			end
			default: known = 1'b0;
		endcase
	end

	// Read-modify-write data
	always_comb begin
		case (csr_req_i.op)
			csr_pkg::CSR_WRITE: wdata = csr_req_i.operand;
			csr_pkg::CSR_SET:   wdata = rdata | csr_req_i.operand;
			csr_pkg::CSR_CLEAR: wdata = rdata & ~csr_req_i.operand;
			default:            wdata = '0;
		endcase
	end

	assign access = (csr_req_i.op != csr_pkg::CSR_NONE);
	assign wr_req = (csr_req_i.op == csr_pkg::CSR_WRITE) || csr_req_i.rs1_nz;
	assign wr_legal = access && wr_req && known && !read_only;

	assign csr_rdata_o = rdata;
	assign csr_illegal_o = access && (!known || (read_only && wr_req));

	assign csr_wr_o.en = wr_legal;
	assign csr_wr_o.sel = sel;
	assign csr_wr_o.data = wdata;

	// Direct mode only
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mtvec_q <= csr_pkg::MTVEC_RESET;
			mscratch_q <= '0;
		end else if (wr_legal) begin
			if (sel == csr_pkg::SEL_MTVEC)
				mtvec_q <= {wdata[31:2], 2'b00};
			if (sel == csr_pkg::SEL_MSCRATCH)
				mscratch_q <= wdata;
		end
	end

	assign mtvec_o = mtvec_q;

endmodule

//--- common/csr_pkg.sv
package csr_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [11:0] csr_addr_t;
	typedef logic [3:0]  cause_t;
	typedef logic [2:0]  irq_lines_t;

	typedef enum logic [2:0] {
		CSR_NONE  = 3'b000,
		CSR_WRITE = 3'b001,
		CSR_SET   = 3'b010,
		CSR_CLEAR = 3'b100
	} csr_op_e;

	// Writable targets, one per register or counter half
	typedef enum logic [3:0] {
		SEL_NONE,
		SEL_MSTATUS,
		SEL_MIE,
		SEL_MTVEC,
		SEL_MSCRATCH,
		SEL_MEPC,
		SEL_MCAUSE,
		SEL_MTVAL,
		SEL_MCYCLE,
		SEL_MCYCLEH,
		SEL_MINSTRET,
		SEL_MINSTRETH
	} csr_sel_e;

	typedef struct packed {
		csr_op_e   op;
		csr_addr_t addr;
		logic      rs1_nz;
		xlen_t     operand;
	} csr_req_t;

	typedef struct packed {
		logic     en;
		csr_sel_e sel;
		xlen_t    data;
	} csr_wr_t;

	typedef struct packed {
		logic   valid;
		cause_t cause;
		xlen_t  pc;
		xlen_t  tval;
	} trap_req_t;

	typedef struct packed {
		logic       mstatus_mie;
		logic       mstatus_mpie;
		irq_lines_t mie_bits;
		xlen_t      mepc;
		logic       mcause_int;
		cause_t     mcause_code;
		xlen_t      mtval;
	} trap_csr_t;

	// Machine CSR addresses
	localparam csr_addr_t ADDR_MVENDORID = 12'hf11;
	localparam csr_addr_t ADDR_MARCHID   = 12'hf12;
	localparam csr_addr_t ADDR_MIMPID    = 12'hf13;
	localparam csr_addr_t ADDR_MHARTID   = 12'hf14;
	localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
	localparam csr_addr_t ADDR_MISA      = 12'h301;
	localparam csr_addr_t ADDR_MIE       = 12'h304;
	localparam csr_addr_t ADDR_MTVEC     = 12'h305;
	localparam csr_addr_t ADDR_MSCRATCH  = 12'h340;
	localparam csr_addr_t ADDR_MEPC      = 12'h341;
	localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
	localparam csr_addr_t ADDR_MTVAL     = 12'h343;
	localparam csr_addr_t ADDR_MIP       = 12'h344;
	localparam csr_addr_t ADDR_MCYCLE    = 12'hb00;
	localparam csr_addr_t ADDR_MINSTRET  = 12'hb02;
	localparam csr_addr_t ADDR_MCYCLEH   = 12'hb80;
	localparam csr_addr_t ADDR_MINSTRETH = 12'hb82;

	// MXL = 32 bit, base integer ISA only
	localparam xlen_t MISA_VALUE  = 32'h4000_0100;
	localparam xlen_t HART_ID     = 32'h0000_0000;
	localparam xlen_t MTVEC_RESET = 32'h0000_0000;

	localparam cause_t IRQ_SOFT      = 4'd3;
	localparam cause_t IRQ_TIMER     = 4'd7;
	localparam cause_t IRQ_EXT       = 4'd11;
	localparam cause_t CAUSE_ILLEGAL = 4'd2;

	// Bit positions of the lines inside irq_lines_t
	localparam int IRQ_LINE_SOFT  = 0;
	localparam int IRQ_LINE_TIMER = 1;
	localparam int IRQ_LINE_EXT   = 2;

	localparam int MSTATUS_MIE_BIT  = 3;
	localparam int MSTATUS_MPIE_BIT = 7;

endpackage
